// ==== hw/bridge_proto_pkg.sv ====
package bridge_proto_pkg;

  localparam int BYTE_W = 8;

  // Command nibbles, low nibble of the first request byte
  localparam logic [3:0] CMD_REG_READ  = 4'h1;
  localparam logic [3:0] CMD_REG_WRITE = 4'h2;

  // Leading bytes of the reply frames
  localparam logic [BYTE_W-1:0] RESP_WRITE_CODE = 8'h05;
  localparam logic [BYTE_W-1:0] RESP_ERR_CODE   = 8'h0F;
  localparam logic [BYTE_W-1:0] ERR_STATUS_CMD  = 8'h01; // Bit 0 flags a bad command

  localparam int WDATA_BYTES = 4; // Write data, MSB first on the wire

  // Reply lengths in bytes
  localparam logic [2:0] READ_RESP_LEN  = 3'd4;
  localparam logic [2:0] WRITE_RESP_LEN = 3'd3;
  localparam logic [2:0] ERR_RESP_LEN   = 3'd2;

  // Which reply frame the sender builds
  typedef enum logic [1:0] {RESP_READ, RESP_WRITE, RESP_ERROR} resp_kind_t;

  // Reply word, always sent from the top byte down
  typedef union packed {
    logic [3:0][BYTE_W-1:0] bytes; // Read data view
    struct packed {
      logic [BYTE_W-1:0] code;
      logic [BYTE_W-1:0] addr;
      logic [BYTE_W-1:0] status;
      logic [BYTE_W-1:0] pad;      // Never sent
    } frame;
  } resp_word_u;

endpackage

// ==== hw/apb_bus_pkg.sv ====
package apb_bus_pkg;

  // Register map is one byte wide
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Values driven on pwrite
  localparam logic APB_READ  = 1'b0;
  localparam logic APB_WRITE = 1'b1;

endpackage

// ==== hw/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser
  import bridge_proto_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rx_done,
  input  logic [BYTE_W-1:0]             rx_data,
  input  logic                          resp_done,
  output logic                          ready,
  output logic                          req_valid,
  output resp_kind_t                    req_kind,
  output logic [BYTE_W-1:0]             req_addr,
  output logic [WDATA_BYTES*BYTE_W-1:0] req_wdata
);

  enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_ISSUED} state;

  logic [$clog2(WDATA_BYTES)-1:0] byte_cnt; // Write data bytes seen
  resp_kind_t                     cmd_kind;

  // Classify the command nibble of the incoming byte
  always_comb begin
    case (rx_data[3:0])
      CMD_REG_READ:  cmd_kind = RESP_READ;
      CMD_REG_WRITE: cmd_kind = RESP_WRITE;
      default:       cmd_kind = RESP_ERROR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      byte_cnt  <= '0;
      req_valid <= 1'b0;
      req_kind  <= RESP_READ;
    end else begin
      req_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rx_done) begin
            req_kind <= cmd_kind;
            if (cmd_kind == RESP_ERROR) begin
              req_valid <= 1'b1; // Bad command, reply without an address
              state     <= S_ISSUED;
            end else begin
              state <= S_ADDR;
            end
          end
        end
        S_ADDR: begin
          if (rx_done) begin
            byte_cnt <= '0;
            if (req_kind == RESP_READ) begin
              req_valid <= 1'b1;
              state     <= S_ISSUED;
            end else begin
              state <= S_DATA;
            end
          end
        end
        S_DATA: begin
          if (rx_done) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (int'(byte_cnt) == WDATA_BYTES - 1) begin
              req_valid <= 1'b1; // Last data byte
              state     <= S_ISSUED;
            end
          end
        end
        S_ISSUED: begin
          // Input is dropped until the reply is out
          if (resp_done)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address and write data capture
  always_ff @(posedge clk) begin
    if (rx_done && state == S_ADDR)
      req_addr <= rx_data;
    if (rx_done && state == S_DATA)
      req_wdata <= {req_wdata[(WDATA_BYTES-1)*BYTE_W-1:0], rx_data}; // MSB arrives first
  end

  assign ready = (state == S_IDLE);

endmodule

// ==== hw/apb_master.sv ====
`timescale 1ns/1ps

module apb_master
  import apb_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  write,
  input  logic [APB_ADDR_W-1:0] addr,
  input  logic [APB_DATA_W-1:0] wdata,
  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output logic [APB_ADDR_W-1:0] paddr,
  output logic [APB_DATA_W-1:0] pwdata,
  input  logic [APB_DATA_W-1:0] prdata,
  input  logic                  pslverr,
  output logic                  acc_done,
  output logic [APB_DATA_W-1:0] acc_rdata,
  output logic                  acc_slverr
);

  enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS, S_COMPLETE} state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      pwrite <= APB_READ;
      paddr  <= '0;
      pwdata <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state  <= S_SETUP;
            pwrite <= write;
            paddr  <= addr;
            pwdata <= wdata;
          end
        end
        S_SETUP:  state <= S_ACCESS;
        S_ACCESS: begin
          state  <= S_COMPLETE; // No pready, access ends here
          pwrite <= APB_READ;
          paddr  <= '0;
          pwdata <= '0;
        end
        default:  state <= S_IDLE;
      endcase
    end
  end

  // Slave answer taken at the end of the access phase
  always_ff @(posedge clk) begin
    if (state == S_ACCESS) begin
      acc_rdata  <= prdata;
      acc_slverr <= pslverr;
    end
  end

  assign psel     = (state == S_SETUP) || (state == S_ACCESS);
  assign penable  = (state == S_ACCESS);
  assign acc_done = (state == S_COMPLETE);

endmodule

// ==== hw/resp_sender.sv ====
`timescale 1ns/1ps

module resp_sender
  import bridge_proto_pkg::*;
  import apb_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  resp_kind_t            kind,
  input  logic [BYTE_W-1:0]     addr,
  input  logic [APB_DATA_W-1:0] rdata,
  input  logic                  slverr,
  output logic                  tx_req,
  input  logic                  tx_grant,
  output logic                  tx_wr,
  output logic [BYTE_W-1:0]     tx_wdata,
  output logic                  resp_done
);

  enum logic [1:0] {S_IDLE, S_REQ, S_SEND, S_DONE} state;

  resp_word_u word_q;
  resp_word_u load_word;
  logic [2:0] load_len;
  logic [2:0] cnt;      // Bytes still to write

  // Frame as seen at start
  always_comb begin
    load_word = '0;
    case (kind)
      RESP_READ: begin
        load_word.bytes = rdata;
        load_len        = READ_RESP_LEN;
      end
      RESP_WRITE: begin
        load_word.frame.code   = RESP_WRITE_CODE;
        load_word.frame.addr   = addr;
        load_word.frame.status = {{(BYTE_W-1){1'b0}}, slverr};
        load_len               = WRITE_RESP_LEN;
      end
      default: begin
        load_word.frame.code = RESP_ERR_CODE;
        load_word.frame.addr = ERR_STATUS_CMD; // Status sits in the second byte here
        load_len             = ERR_RESP_LEN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_REQ;
            cnt   <= load_len;
          end
        end
        S_REQ: begin
          if (tx_grant)
            state <= S_SEND;
        end
        S_SEND: begin
          cnt <= cnt - 1'b1;
          if (cnt == 3'd1)
            state <= S_DONE; // Last byte goes out this cycle
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Reply shift register, top byte is on the bus
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start)
      word_q <= load_word;
    else if (state == S_SEND)
      word_q.bytes <= {word_q.bytes[2:0], {BYTE_W{1'b0}}};
  end

  assign tx_req    = (state == S_REQ) || (state == S_SEND);
  assign tx_wr     = (state == S_SEND);
  assign tx_wdata  = word_q.bytes[3];
  assign resp_done = (state == S_DONE);

endmodule

// ==== hw/uart_reg_bridge.sv ====
`timescale 1ns/1ps

module uart_reg_bridge
  import bridge_proto_pkg::*;
  import apb_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx_done,
  input  logic [BYTE_W-1:0]     rx_data,
  output logic                  ready,
  output logic                  tx_req,
  input  logic                  tx_grant,
  output logic                  tx_wr,
  output logic [BYTE_W-1:0]     tx_wdata,
  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output logic [APB_ADDR_W-1:0] paddr,
  output logic [APB_DATA_W-1:0] pwdata,
  input  logic [APB_DATA_W-1:0] prdata,
  input  logic                  pslverr
);

  logic                  req_valid;
  resp_kind_t            req_kind;
  logic [BYTE_W-1:0]     req_addr;
  logic [APB_DATA_W-1:0] req_wdata;
  logic                  acc_start;
  logic                  acc_write;
  logic                  acc_done;
  logic [APB_DATA_W-1:0] acc_rdata;
  logic                  acc_slverr;
  logic                  send_start;
  logic                  resp_done;

  cmd_parser u_parser (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_done   (rx_done),
    .rx_data   (rx_data),
    .resp_done (resp_done),
    .ready     (ready),
    .req_valid (req_valid),
    .req_kind  (req_kind),
    .req_addr  (req_addr),
    .req_wdata (req_wdata)
  );

  // Only reads and writes touch the bus
  assign acc_start = req_valid && (req_kind != RESP_ERROR);
  assign acc_write = (req_kind == RESP_WRITE) ? APB_WRITE : APB_READ;

  apb_master u_apb (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (acc_start),
    .write      (acc_write),
    .addr       (req_addr),
    .wdata      (req_wdata),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .acc_done   (acc_done),
    .acc_rdata  (acc_rdata),
    .acc_slverr (acc_slverr)
  );

  // Error replies skip the APB access
  assign send_start = acc_done || (req_valid && req_kind == RESP_ERROR);

  resp_sender u_sender (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (send_start),
    .kind      (req_kind),
    .addr      (req_addr),
    .rdata     (acc_rdata),
    .slverr    (acc_slverr),
    .tx_req    (tx_req),
    .tx_grant  (tx_grant),
    .tx_wr     (tx_wr),
    .tx_wdata  (tx_wdata),
    .resp_done (resp_done)
  );

endmodule

// ==== testbench/tb_uart_reg_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_reg_bridge;

  localparam int MAX_TESTS    = 16;
  localparam int RESET_CYCLES = 3;

  logic        clk      = 1'b0;
  logic        tx_grant = 1'b0;
  logic        rst_n;
  logic        rx_done;
  logic [7:0]  rx_data;
  logic [31:0] prdata;
  logic        pslverr;
  logic        ready;
  logic        tx_req;
  logic        tx_wr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  tx_wdata;
  logic [7:0]  paddr;
  logic [31:0] pwdata;

  // Test table from the stimulus file
  string       t_name  [MAX_TESTS];
  int          t_nreq  [MAX_TESTS];
  logic [7:0]  t_req   [MAX_TESTS][6];
  logic [31:0] t_rdata [MAX_TESTS];
  logic        t_err   [MAX_TESTS];
  int          t_stall [MAX_TESTS];
  int          t_nrsp  [MAX_TESTS];
  logic [7:0]  t_rsp   [MAX_TESTS][4];

  logic [7:0]  rsp_q [$];  // Every byte written to the transmitter
  int          apb_cnt     = 0;
  logic [7:0]  apb_addr;
  logic        apb_write;
  logic [31:0] apb_wdata;
  int          stall_cnt   = 0;
  int          mon_err     = 0;
  int          err_cnt     = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          grant_delay = 0;
  int          grant_wait  = 0;
  logic        grant_armed = 1'b0;
  logic [31:0] lfsr        = 32'h2a5991b3;

  uart_reg_bridge UUT (.*);

  always #10 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int random_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    err_cnt++;
  endtask

  task automatic load_stimulus(output int n_tests);
    int            fd;
    int            rc;
    int            nreq;
    int            nrsp;
    int            stall;
    string         tok;
    logic [1023:0] rest;
    logic [31:0]   v;
    logic [31:0]   rd;
    n_tests = 0;
    fd = $fopen("testbench/bridge_stimulus.txt", "r");
    if (fd == 0)
      return;
    while (n_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        rc = $fgets(rest, fd); // Column notes
        continue;
      end
      t_name[n_tests] = tok;
      rc = $fscanf(fd, "%d", nreq);
      t_nreq[n_tests] = nreq;
      for (int i = 0; i < nreq; i++) begin
        rc = $fscanf(fd, "%h", v);
        t_req[n_tests][i] = v[7:0];
      end
      rc = $fscanf(fd, "%h %h %d %d", rd, v, stall, nrsp);
      t_rdata[n_tests] = rd;
      t_err[n_tests]   = v[0];
      t_stall[n_tests] = stall;
      t_nrsp[n_tests]  = nrsp;
      for (int i = 0; i < nrsp; i++) begin
        rc = $fscanf(fd, "%h", v);
        t_rsp[n_tests][i] = v[7:0];
      end
      n_tests++;
    end
    $fclose(fd);
  endtask

  // Transmitter arbiter, grant follows tx_req after grant_delay cycles
  always @(posedge clk) begin
    if (!tx_req) begin
      tx_grant    <= 1'b0;
      grant_armed <= 1'b0;
    end else if (!grant_armed) begin
      grant_armed <= 1'b1;
      grant_wait  <= grant_delay;
    end else if (grant_wait == 0) begin
      tx_grant <= 1'b1;
    end else begin
      grant_wait <= grant_wait - 1;
    end
  end

  // APB slave record and transmitter capture
  always @(negedge clk) begin
    if (tx_wr)
      rsp_q.push_back(tx_wdata);
    if (psel && penable) begin
      apb_cnt++;
      apb_addr  = paddr;
      apb_write = pwrite;
      apb_wdata = pwdata;
    end
    if (tx_req && !tx_grant)
      stall_cnt++;
    assert (!tx_wr || tx_grant) else begin
      $display("tx_wr was high while tx_grant was low");
      mon_err++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the bridge stopped responding", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int         n_tests;
    int         n_pass;
    int         err_at;
    int         mon_at;
    int         rsp_base;
    int         apb_base;
    int         stall_base;
    int         got;
    logic [3:0] cmd;
    rst_n   <= 1'b0;
    rx_done <= 1'b0;
    rx_data <= 8'h00;
    prdata  <= 32'h0;
    pslverr <= 1'b0;
    n_pass = 0;
    load_stimulus(n_tests);
    if (n_tests == 0) begin
      $display("No tests could be read from the stimulus file");
      err_cnt++;
    end
    cycle_limit = RESET_CYCLES;
    for (int t = 0; t < n_tests; t++)
      cycle_limit += 2 * t_nreq[t] + 20 + t_stall[t];

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    err_at = err_cnt;
    assert (!tx_req && !tx_wr && !psel && !penable) else begin
      $display("tx_req, tx_wr, psel or penable was high after reset");
      err_cnt++;
    end
    assert (ready) else begin
      $display("ready was low after reset");
      err_cnt++;
    end
    $display("reset_values: %s", (err_cnt == err_at) ? "pass" : "fail");
    if (err_cnt == err_at)
      n_pass++;

    for (int t = 0; t < n_tests; t++) begin
      err_at      = err_cnt;
      mon_at      = mon_err;
      rsp_base    = rsp_q.size();
      apb_base    = apb_cnt;
      stall_base  = stall_cnt;
      grant_delay = random_bits(2) + t_stall[t];
      while (!ready)
        @(negedge clk);
      for (int i = 0; i < t_nreq[t]; i++) begin
        @(posedge clk);
        if (i == 0) begin
          prdata  <= t_rdata[t];
          pslverr <= t_err[t];
        end
        rx_done <= 1'b1;
        rx_data <= t_req[t][i];
        @(posedge clk);
        rx_done <= 1'b0;
      end
      if (t_stall[t] > 0) begin
        do @(negedge clk); while (!tx_req);
        assert (!ready) else begin
          $display("%s: ready was high while a reply was pending", t_name[t]);
          err_cnt++;
        end
        @(posedge clk);
        rx_done <= 1'b1; // Stray read command, must be dropped
        rx_data <= 8'h01;
        @(posedge clk);
        rx_done <= 1'b0;
      end
      do @(negedge clk); while (!ready);

      got = rsp_q.size() - rsp_base;
      assert (got == t_nrsp[t]) else report_mismatch(t_name[t], "reply length", t_nrsp[t], got);
      for (int i = 0; i < t_nrsp[t] && i < got; i++)
        assert (rsp_q[rsp_base + i] == t_rsp[t][i])
          else report_mismatch(t_name[t], $sformatf("reply byte %0d", i),
                               32'(t_rsp[t][i]), 32'(rsp_q[rsp_base + i]));
      cmd = t_req[t][0][3:0];
      if (cmd == 4'h1 || cmd == 4'h2) begin
        assert (apb_cnt - apb_base == 1)
          else report_mismatch(t_name[t], "APB accesses", 1, apb_cnt - apb_base);
        assert (apb_addr == t_req[t][1])
          else report_mismatch(t_name[t], "paddr", 32'(t_req[t][1]), 32'(apb_addr));
        assert (apb_write == (cmd == 4'h2))
          else report_mismatch(t_name[t], "pwrite", 32'(cmd == 4'h2), 32'(apb_write));
      end else begin
        assert (apb_cnt == apb_base)
          else report_mismatch(t_name[t], "APB accesses", 0, apb_cnt - apb_base);
      end
      if (cmd == 4'h2)
        assert (apb_wdata == {t_req[t][2], t_req[t][3], t_req[t][4], t_req[t][5]})
          else report_mismatch(t_name[t], "pwdata",
                               {t_req[t][2], t_req[t][3], t_req[t][4], t_req[t][5]}, apb_wdata);
      if (t_stall[t] > 0)
        assert (stall_cnt - stall_base >= t_stall[t]) else begin
          $display("%s: tx_req was not held while the grant was withheld", t_name[t]);
          err_cnt++;
        end
      if (err_cnt == err_at && mon_err == mon_at) begin
        n_pass++;
        $display("%s: pass", t_name[t]);
      end else begin
        $display("%s: fail", t_name[t]);
      end
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", n_tests + 1, n_pass,
             n_tests + 1 - n_pass);
    if (err_cnt == 0 && mon_err == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
hw/bridge_proto_pkg.sv
hw/apb_bus_pkg.sv
hw/cmd_parser.sv
hw/apb_master.sv
hw/resp_sender.sv
hw/uart_reg_bridge.sv
testbench/tb_uart_reg_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_uart_reg_bridge \
  --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Test passed" sim.log; then
  exit 0
fi
exit 1

// ==== testbench/bridge_stimulus.txt ====
# name nreq request_bytes prdata pslverr grant_stall nrsp reply_bytes
# bytes and prdata in hex, nreq, grant_stall and nrsp in decimal
rd_basic     2 01 3c             12345678 0 0 4 12 34 56 78
rd_upper_nib 2 41 a5             deadbeef 0 0 4 de ad be ef
wr_basic     6 02 10 a1 b2 c3 d4 00000000 0 0 3 05 10 00
wr_slverr    6 02 7f 00 00 00 01 00000000 1 0 3 05 7f 01
rd_slverr    2 01 ff             cafef00d 1 0 4 ca fe f0 0d
bad_cmd_0    1 00                00000000 0 0 2 0f 01
bad_cmd_3    1 03                00000000 0 0 2 0f 01
bad_cmd_f    1 0f                00000000 0 0 2 0f 01
bad_cmd_4    1 34                00000000 0 0 2 0f 01
wr_stall     6 02 42 01 02 03 04 00000000 0 6 3 05 42 00
rd_stall     2 01 80             0badf00d 0 5 4 0b ad f0 0d
wr_upper_nib 6 92 00 ff ff ff ff 00000000 0 0 3 05 00 00
rd_after     2 01 42             a5a55a5a 0 0 4 a5 a5 5a 5a
